//--- hdl/eth_buf_ram.sv
`timescale 1ns/1ps

module eth_buf_ram import eth_pkg::*; #(
  parameter int BUFFER_W = 11
) (
  input  logic                clk_i,
  input  logic                w_en_i,
  input  logic [BUFFER_W-1:0] w_addr_i,
  input  byte_t               w_data_i,
  input  logic                r_en_i,
  input  logic [BUFFER_W-1:0] r_addr_i,
  output byte_t               r_data_o
);

  byte_t mem [2**BUFFER_W];

  always_ff @(posedge clk_i) begin
    if (w_en_i) mem[w_addr_i] <= w_data_i;
    if (r_en_i) r_data_o <= mem[r_addr_i];  // One cycle read latency
  end

endmodule

//--- hdl/eth_core.sv
`timescale 1ns/1ps

module eth_core import eth_pkg::*; #(
  parameter int BUFFER_W = 11
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Host transmit side
  input  logic                tx_wen_i,
  input  logic [BUFFER_W-1:0] tx_waddr_i,
  input  byte_t               tx_wdata_i,
  input  logic                send_i,
  input  nbytes_t             tx_nbytes_i,
  input  logic                crc_en_i,
  output logic                tx_ready_o,
  // Host receive side
  input  logic                rx_ren_i,
  input  logic [BUFFER_W-1:0] rx_raddr_i,
  output byte_t               rx_rdata_o,
  output logic                rx_rcvd_o,
  output nbytes_t             rx_nbytes_o,
  output logic                crc_err_o,
  input  logic                rcv_ack_i,
  // Interrupts and counters
  input  logic [1:0]          int_mask_i,
  input  logic [1:0]          int_clr_i,
  output logic [1:0]          int_source_o,
  output logic                irq_o,
  output frame_cnt_t          tx_frames_o,
  output frame_cnt_t          rx_frames_o,
  output frame_cnt_t          rx_err_frames_o,
  // MII
  output logic                mii_tx_en_o,
  output nibble_t             mii_txd_o,
  input  logic                mii_rx_dv_i,
  input  nibble_t             mii_rxd_i
);

  logic [BUFFER_W-1:0] tx_raddr;
  byte_t               tx_rdata;
  logic                rx_wen;
  logic [BUFFER_W-1:0] rx_waddr;
  byte_t               rx_wdata;
  logic                tx_done;
  logic                rx_done;

  // Written by the host, read by the transmitter
  eth_buf_ram #(.BUFFER_W(BUFFER_W)) tx_buf (
    .clk_i   (clk_i),
    .w_en_i  (tx_wen_i),
    .w_addr_i(tx_waddr_i),
    .w_data_i(tx_wdata_i),
    .r_en_i  (1'b1),
    .r_addr_i(tx_raddr),
    .r_data_o(tx_rdata)
  );

  // Written by the receiver, read by the host
  eth_buf_ram #(.BUFFER_W(BUFFER_W)) rx_buf (
    .clk_i   (clk_i),
    .w_en_i  (rx_wen),
    .w_addr_i(rx_waddr),
    .w_data_i(rx_wdata),
    .r_en_i  (rx_ren_i),
    .r_addr_i(rx_raddr_i),
    .r_data_o(rx_rdata_o)
  );

  eth_tx #(.BUFFER_W(BUFFER_W)) u_tx (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .send_i     (send_i),
    .crc_en_i   (crc_en_i),
    .nbytes_i   (tx_nbytes_i),
    .ready_o    (tx_ready_o),
    .done_o     (tx_done),
    .buf_addr_o (tx_raddr),
    .buf_data_i (tx_rdata),
    .mii_tx_en_o(mii_tx_en_o),
    .mii_txd_o  (mii_txd_o)
  );

  eth_rx #(.BUFFER_W(BUFFER_W)) u_rx (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .mii_rx_dv_i(mii_rx_dv_i),
    .mii_rxd_i  (mii_rxd_i),
    .rcv_ack_i  (rcv_ack_i),
    .buf_wen_o  (rx_wen),
    .buf_addr_o (rx_waddr),
    .buf_data_o (rx_wdata),
    .done_o     (rx_done),
    .rcvd_o     (rx_rcvd_o),
    .nbytes_o   (rx_nbytes_o),
    .crc_err_o  (crc_err_o)
  );

  eth_ctrl u_ctrl (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .tx_done_i      (tx_done),
    .rx_done_i      (rx_done),
    .rx_crc_err_i   (crc_err_o),
    .int_mask_i     (int_mask_i),
    .int_clr_i      (int_clr_i),
    .int_source_o   (int_source_o),
    .irq_o          (irq_o),
    .tx_frames_o    (tx_frames_o),
    .rx_frames_o    (rx_frames_o),
    .rx_err_frames_o(rx_err_frames_o)
  );

endmodule

//--- hdl/eth_crc32.sv
`timescale 1ns/1ps

module eth_crc32 import eth_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    clr_i,
  input  logic    en_i,
  input  nibble_t data_i,
  output crc_t    crc_o
);

  crc_t crc_nxt;
  logic fb;

  // Four serial steps per nibble, bit 0 first
  always_comb begin
    crc_nxt = crc_o;
    fb      = 1'b0;
    for (int i = 0; i < 4; i++) begin
      fb      = crc_nxt[0] ^ data_i[i];
      crc_nxt = {1'b0, crc_nxt[31:1]} ^ (fb ? CRC_POLY : '0);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      crc_o <= CRC_INIT;
    end else if (clr_i) begin
      crc_o <= CRC_INIT;
    end else if (en_i) begin
      crc_o <= crc_nxt;
    end
  end

endmodule

//--- hdl/eth_ctrl.sv
`timescale 1ns/1ps

module eth_ctrl import eth_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       tx_done_i,
  input  logic       rx_done_i,
  input  logic       rx_crc_err_i,
  input  logic [1:0] int_mask_i,
  input  logic [1:0] int_clr_i,
  output logic [1:0] int_source_o,
  output logic       irq_o,
  output frame_cnt_t tx_frames_o,
  output frame_cnt_t rx_frames_o,
  output frame_cnt_t rx_err_frames_o
);

  logic [1:0] done_vec;

  assign done_vec = {rx_done_i, tx_done_i};  // Bit 0 tx, bit 1 rx
  assign irq_o    = |(int_source_o & int_mask_i);

  // Sticky sources, a new done wins over a clear
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      int_source_o <= '0;
    end else begin
      int_source_o <= (int_source_o & ~int_clr_i) | done_vec;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_frames_o     <= '0;
      rx_frames_o     <= '0;
      rx_err_frames_o <= '0;
    end else begin
      if (tx_done_i) tx_frames_o <= tx_frames_o + 1'b1;
      if (rx_done_i) begin
        rx_frames_o <= rx_frames_o + 1'b1;
        if (rx_crc_err_i) rx_err_frames_o <= rx_err_frames_o + 1'b1;
      end
    end
  end

endmodule

//--- hdl/eth_pkg.sv
package eth_pkg;

  // MII and buffer data words
  typedef logic [3:0]  nibble_t;
  typedef logic [7:0]  byte_t;

  typedef logic [31:0] crc_t;
  typedef logic [15:0] frame_cnt_t;
  typedef logic [10:0] nbytes_t;    // Frame length in bytes

  // Framing
  localparam nibble_t PREAMBLE_NIBBLE = 4'h5;  // Sent 15 times
  localparam nibble_t SFD_NIBBLE      = 4'hD;

  // CRC-32 in reflected form, shifted LSB first
  localparam crc_t CRC_POLY    = 32'hEDB88320;
  localparam crc_t CRC_INIT    = 32'hFFFFFFFF;
  // Register value after a good frame plus its FCS, before inversion
  localparam crc_t CRC_RESIDUE = 32'hDEBB20E3;

endpackage

//--- hdl/eth_rx.sv
`timescale 1ns/1ps

module eth_rx import eth_pkg::*; #(
  parameter int BUFFER_W = 11
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                mii_rx_dv_i,
  input  nibble_t             mii_rxd_i,
  input  logic                rcv_ack_i,
  output logic                buf_wen_o,
  output logic [BUFFER_W-1:0] buf_addr_o,
  output byte_t               buf_data_o,
  output logic                done_o,
  output logic                rcvd_o,
  output nbytes_t             nbytes_o,
  output logic                crc_err_o
);

  typedef enum logic [2:0] {S_IDLE, S_PREAMBLE, S_DATA, S_HOLD, S_DROP} state_t;

  state_t              state;
  logic                half;      // High nibble of the byte is on the pins
  nibble_t             lo_q;
  logic [BUFFER_W-1:0] wr_addr;
  logic                err_q;
  logic                crc_bad;
  crc_t                crc;

  assign buf_wen_o  = (state == S_DATA) & mii_rx_dv_i & half;
  assign buf_addr_o = wr_addr;
  assign buf_data_o = {mii_rxd_i, lo_q};
  assign done_o     = (state == S_DATA) & ~mii_rx_dv_i;
  assign crc_bad    = (crc != CRC_RESIDUE);
  // Live while receiving so the flag lines up with done_o
  assign crc_err_o  = (state == S_DATA) ? crc_bad : err_q;

  eth_crc32 u_crc (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .clr_i   (state == S_PREAMBLE),
    .en_i    ((state == S_DATA) & mii_rx_dv_i),
    .data_i  (mii_rxd_i),
    .crc_o   (crc)
  );

  always_ff @(posedge clk_i) begin
    if ((state == S_DATA) && mii_rx_dv_i && !half) lo_q <= mii_rxd_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state    <= S_IDLE;
      half     <= 1'b0;
      wr_addr  <= '0;
      rcvd_o   <= 1'b0;
      nbytes_o <= '0;
      err_q    <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (mii_rx_dv_i) state <= S_PREAMBLE;
        end
        S_PREAMBLE: begin
          if (!mii_rx_dv_i) begin
            state <= S_IDLE;
          end else if (mii_rxd_i == SFD_NIBBLE) begin
            state   <= S_DATA;
            half    <= 1'b0;
            wr_addr <= '0;
          end
        end
        S_DATA: begin
          if (mii_rx_dv_i) begin
            half <= ~half;
            if (half) wr_addr <= wr_addr + 1'b1;
          end else begin  // End of frame
            state    <= S_HOLD;
            rcvd_o   <= 1'b1;
            nbytes_o <= nbytes_t'(wr_addr);
            err_q    <= crc_bad;
          end
        end
        S_HOLD: begin
          if (mii_rx_dv_i)    state <= S_DROP;  // New frame while pending
          else if (rcv_ack_i) state <= S_IDLE;
        end
        S_DROP: begin
          if (!mii_rx_dv_i) state <= (rcvd_o && !rcv_ack_i) ? S_HOLD : S_IDLE;
        end
        default: state <= S_IDLE;
      endcase

      if (rcv_ack_i && (state == S_HOLD || state == S_DROP)) rcvd_o <= 1'b0;
    end
  end

endmodule

//--- hdl/eth_tx.sv
`timescale 1ns/1ps

module eth_tx import eth_pkg::*; #(
  parameter int BUFFER_W = 11
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                send_i,
  input  logic                crc_en_i,
  input  nbytes_t             nbytes_i,
  output logic                ready_o,
  output logic                done_o,
  output logic [BUFFER_W-1:0] buf_addr_o,
  input  byte_t               buf_data_i,
  output logic                mii_tx_en_o,
  output nibble_t             mii_txd_o
);

  typedef enum logic [1:0] {S_IDLE, S_PREAMBLE, S_DATA, S_FCS} state_t;

  state_t              state;
  logic                accept;
  logic [11:0]         cnt;       // Nibble index within the current state
  nbytes_t             nbytes_q;
  logic                crc_en_q;
  logic [BUFFER_W-1:0] rd_addr;
  logic                last_data;
  nibble_t             txd_nxt;
  crc_t                crc;

  assign accept     = send_i & ready_o & (state == S_IDLE);
  assign last_data  = (cnt == {nbytes_q, 1'b0} - 12'd1);
  assign buf_addr_o = rd_addr;

  always_comb begin
    case (state)
      S_PREAMBLE: txd_nxt = (cnt == 12'd15) ? SFD_NIBBLE : PREAMBLE_NIBBLE;
      S_DATA:     txd_nxt = cnt[0] ? buf_data_i[7:4] : buf_data_i[3:0];  // Low half first
      S_FCS:      txd_nxt = ~crc[{cnt[2:0], 2'b00} +: 4];
      default:    txd_nxt = '0;
    endcase
  end

  eth_crc32 u_crc (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .clr_i   (accept),
    .en_i    (state == S_DATA),
    .data_i  (txd_nxt),
    .crc_o   (crc)
  );

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state    <= S_IDLE;
      cnt      <= '0;
      nbytes_q <= '0;
      crc_en_q <= 1'b0;
      rd_addr  <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (accept) begin
            state    <= S_PREAMBLE;
            cnt      <= '0;
            nbytes_q <= nbytes_i;
            crc_en_q <= crc_en_i;
            rd_addr  <= '0;
          end
        end
        S_PREAMBLE: begin
          cnt <= cnt + 12'd1;
          if (cnt == 12'd15) begin  // SFD goes out now
            cnt <= '0;
            if (nbytes_q != '0) state <= S_DATA;
            else if (crc_en_q)  state <= S_FCS;
            else                state <= S_IDLE;
          end
        end
        S_DATA: begin
          cnt <= cnt + 12'd1;
          // Next byte is fetched while the high half goes out
          if (!cnt[0]) rd_addr <= rd_addr + 1'b1;
          if (last_data) begin
            cnt   <= '0;
            state <= crc_en_q ? S_FCS : S_IDLE;
          end
        end
        S_FCS: begin
          cnt <= cnt + 12'd1;
          if (cnt == 12'd7) state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Pin stage, one cycle behind the state machine
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mii_tx_en_o <= 1'b0;
      mii_txd_o   <= '0;
      ready_o     <= 1'b1;
      done_o      <= 1'b0;
    end else begin
      mii_tx_en_o <= (state != S_IDLE);
      mii_txd_o   <= txd_nxt;
      ready_o     <= (state == S_IDLE);
      done_o      <= (state == S_IDLE) & ~ready_o;  // Last nibble just left
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module eth_core_tb -f sim.f -o eth_core_sim \
  && ./obj_dir/eth_core_sim | tee sim.log
grep -qx "sim passed" sim.log && echo "Result: PASS" || { echo "Result: FAIL"; exit 1; }

//--- sim.f
hdl/eth_pkg.sv
hdl/eth_crc32.sv
hdl/eth_buf_ram.sv
hdl/eth_tx.sv
hdl/eth_rx.sv
hdl/eth_ctrl.sv
hdl/eth_core.sv
verif/eth_core_tb.sv

//--- verif/eth_core_tb.sv
`timescale 1ns/1ps

module eth_core_tb import eth_pkg::*; ();

  localparam int BUFFER_W = 11;
  localparam int NFRAMES  = 8;

  logic                clk = 1'b0;
  logic                arst_n;
  logic                tx_wen;
  logic [BUFFER_W-1:0] tx_waddr;
  byte_t               tx_wdata;
  logic                send;
  nbytes_t             tx_nbytes;
  logic                crc_en;
  logic                tx_ready;
  logic                rx_ren;
  logic [BUFFER_W-1:0] rx_raddr;
  byte_t               rx_rdata;
  logic                rx_rcvd;
  nbytes_t             rx_nbytes;
  logic                crc_err;
  logic                rcv_ack;
  logic [1:0]          int_mask;
  logic [1:0]          int_clr;
  logic [1:0]          int_source;
  logic                irq;
  frame_cnt_t          tx_frames;
  frame_cnt_t          rx_frames;
  frame_cnt_t          rx_err_frames;
  logic                mii_tx_en;
  nibble_t             mii_txd;
  logic                mii_rx_dv = 1'b0;
  nibble_t             mii_rxd = '0;

  integer seed = 32'hb673;
  int     errors = 0;
  int     checks = 0;
  int     lens [NFRAMES];
  int     limit_cycles = 0;
  int     lb_cnt = 0;       // Nibble index on the transmit pins
  bit     corrupt_en = 1'b0;
  int     corrupt_idx = 0;
  int     tx_sent = 0;
  int     rx_acc = 0;
  int     err_acc = 0;
  byte_t   payload [$];
  byte_t   exp_rx [$];      // Bytes the receive buffer should hold
  nibble_t exp_nib [$];
  nibble_t tx_nib [$];

  always #2 clk = ~clk;

  eth_core #(.BUFFER_W(BUFFER_W)) dut_i (
    .clk_i(clk), .arst_n_i(arst_n),
    .tx_wen_i(tx_wen), .tx_waddr_i(tx_waddr), .tx_wdata_i(tx_wdata),
    .send_i(send), .tx_nbytes_i(tx_nbytes), .crc_en_i(crc_en), .tx_ready_o(tx_ready),
    .rx_ren_i(rx_ren), .rx_raddr_i(rx_raddr), .rx_rdata_o(rx_rdata),
    .rx_rcvd_o(rx_rcvd), .rx_nbytes_o(rx_nbytes), .crc_err_o(crc_err), .rcv_ack_i(rcv_ack),
    .int_mask_i(int_mask), .int_clr_i(int_clr), .int_source_o(int_source), .irq_o(irq),
    .tx_frames_o(tx_frames), .rx_frames_o(rx_frames), .rx_err_frames_o(rx_err_frames),
    .mii_tx_en_o(mii_tx_en), .mii_txd_o(mii_txd),
    .mii_rx_dv_i(mii_rx_dv), .mii_rxd_i(mii_rxd)
  );

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Bitwise reflected CRC-32 over each byte LSB first without final inversion
  function automatic crc_t crc_ref(input byte_t data [$]);
    crc_t c;
    logic fb;
    c = 32'hFFFFFFFF;
    foreach (data[i]) begin
      for (int b = 0; b < 8; b++) begin
        fb = c[0] ^ data[i][b];
        c  = (c >> 1) ^ (fb ? 32'hEDB88320 : 32'h0);
      end
    end
    return c;
  endfunction

  // Loopback with an optional single nibble error
  always @(posedge clk) begin
    mii_rx_dv <= mii_tx_en;
    if (corrupt_en && mii_tx_en && lb_cnt == corrupt_idx) mii_rxd <= mii_txd ^ 4'h8;
    else mii_rxd <= mii_txd;
    lb_cnt <= mii_tx_en ? lb_cnt + 1 : 0;
  end

  always @(posedge clk) begin
    if (mii_tx_en) begin
      tx_nib.push_back(mii_txd);
      check("tx_ready during frame", 32'd0, 32'(tx_ready));
    end
  end

  task automatic build_frame(input int n, input bit use_crc);
    crc_t fcs;
    payload = {};
    exp_nib = {};
    for (int i = 0; i < n; i++) payload.push_back(byte_t'($random(seed)));
    fcs    = ~crc_ref(payload);
    exp_rx = payload;
    repeat (15) exp_nib.push_back(4'h5);
    exp_nib.push_back(4'hD);
    foreach (payload[i]) begin
      exp_nib.push_back(payload[i][3:0]);  // Low half first
      exp_nib.push_back(payload[i][7:4]);
    end
    if (use_crc) begin
      for (int i = 0; i < 4; i++) exp_rx.push_back(fcs[8*i +: 8]);
      for (int i = 0; i < 8; i++) exp_nib.push_back(fcs[4*i +: 4]);
    end
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      tx_wen   <= 1'b1;
      tx_waddr <= BUFFER_W'(i);
      tx_wdata <= payload[i];
    end
    @(posedge clk);
    tx_wen <= 1'b0;
  endtask

  task automatic send_frame(input bit use_crc, input string name);
    tx_nib = {};
    @(posedge clk);
    send      <= 1'b1;
    tx_nbytes <= nbytes_t'(payload.size());
    crc_en    <= use_crc;
    @(posedge clk);
    send <= 1'b0;
    @(negedge clk);
    while (tx_ready) @(negedge clk);
    while (!tx_ready) @(negedge clk);
    tx_sent++;
    check({name, " nibble count"}, 32'(exp_nib.size()), 32'(tx_nib.size()));
    foreach (exp_nib[i]) begin
      if (i < tx_nib.size())
        check($sformatf("%s nibble %0d", name, i), 32'(exp_nib[i]), 32'(tx_nib[i]));
    end
    check({name, " tx_en after frame"}, 32'd0, 32'(mii_tx_en));
  endtask

  task automatic read_rx_byte(input int addr, output byte_t d);
    @(posedge clk);
    rx_ren   <= 1'b1;
    rx_raddr <= BUFFER_W'(addr);
    @(posedge clk);
    rx_ren <= 1'b0;
    @(negedge clk);
    d = rx_rdata;
  endtask

  task automatic check_rx(input string name);
    byte_t d;
    crc_t  res;
    res = crc_ref(exp_rx);
    check({name, " rx_rcvd"}, 32'd1, 32'(rx_rcvd));
    check({name, " rx_nbytes"}, 32'(exp_rx.size()), 32'(rx_nbytes));
    check({name, " crc_err"}, 32'(res != 32'hDEBB20E3), 32'(crc_err));
    foreach (exp_rx[i]) begin
      read_rx_byte(i, d);
      check($sformatf("%s rx byte %0d", name, i), 32'(exp_rx[i]), 32'(d));
    end
  endtask

  task automatic accept_frame(input string name);
    @(negedge clk);
    while (!rx_rcvd) @(negedge clk);
    rx_acc++;
    if (crc_ref(exp_rx) != 32'hDEBB20E3) err_acc++;
    check_rx(name);
  endtask

  task automatic ack_rx();
    @(posedge clk);
    rcv_ack <= 1'b1;
    @(posedge clk);
    rcv_ack <= 1'b0;
    @(negedge clk);
    check("rx_rcvd after ack", 32'd0, 32'(rx_rcvd));
  endtask

  task automatic clear_sources(input logic [1:0] bits);
    @(posedge clk);
    int_clr <= bits;
    @(posedge clk);
    int_clr <= 2'b00;
    @(negedge clk);
  endtask

  initial begin
    int total;
    int k;
    byte_t saved [$];
    arst_n    = 1'b0;
    tx_wen    = 1'b0;
    tx_waddr  = '0;
    tx_wdata  = '0;
    send      = 1'b0;
    tx_nbytes = '0;
    crc_en    = 1'b0;
    rx_ren    = 1'b0;
    rx_raddr  = '0;
    rcv_ack   = 1'b0;
    int_mask  = 2'b00;
    int_clr   = 2'b00;
    total = 0;
    for (int i = 0; i < NFRAMES; i++) begin
      lens[i] = 1 + int'($unsigned($random(seed)) % 60);
      total += 2 * lens[i] + 24;
    end
    limit_cycles = 4 * total + 200;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check("tx_ready after reset", 32'd1, 32'(tx_ready));
    check("tx_en after reset", 32'd0, 32'(mii_tx_en));
    check("rx_rcvd after reset", 32'd0, 32'(rx_rcvd));
    check("crc_err after reset", 32'd0, 32'(crc_err));
    check("irq after reset", 32'd0, 32'(irq));

    for (int f = 0; f < 3; f++) begin
      build_frame(lens[f], 1'b1);
      send_frame(1'b1, $sformatf("frame%0d", f));
      accept_frame($sformatf("frame%0d", f));
      ack_rx();
    end

    // One flipped payload nibble
    k = int'($unsigned($random(seed)) % (2 * lens[3]));
    build_frame(lens[3], 1'b1);
    corrupt_idx = 16 + k;
    corrupt_en  = 1'b1;
    exp_rx[k/2] = exp_rx[k/2] ^ ((k % 2 != 0) ? 8'h80 : 8'h08);
    send_frame(1'b1, "corrupt");
    corrupt_en = 1'b0;
    accept_frame("corrupt");
    check("corrupt rx_err_frames", 32'(err_acc), 32'(rx_err_frames));
    ack_rx();

    build_frame(lens[4], 1'b0);
    send_frame(1'b0, "nocrc");
    accept_frame("nocrc");
    ack_rx();

    // Only transmit done reaches irq
    @(posedge clk);
    int_mask <= 2'b01;
    clear_sources(2'b11);
    check("sources cleared", 32'd0, 32'(int_source));
    check("irq idle", 32'd0, 32'(irq));
    build_frame(lens[5], 1'b1);
    send_frame(1'b1, "irq");
    check("irq at tx end", 32'd0, 32'(irq));
    @(negedge clk);
    check("tx source", 32'd1, 32'(int_source[0]));
    check("irq after tx", 32'd1, 32'(irq));
    accept_frame("irq");
    check("both sources", 32'd3, 32'(int_source));
    clear_sources(2'b01);
    check("rx source only", 32'd2, 32'(int_source));
    check("irq rx masked", 32'd0, 32'(irq));
    clear_sources(2'b10);
    check("sources after clear", 32'd0, 32'(int_source));
    check("tx_frames", 32'(tx_sent), 32'(tx_frames));
    check("rx_frames", 32'(rx_acc), 32'(rx_frames));
    ack_rx();

    // Second frame arrives while the first is pending
    build_frame(lens[6], 1'b1);
    send_frame(1'b1, "pending");
    accept_frame("pending");
    saved = exp_rx;
    build_frame(lens[7], 1'b1);
    send_frame(1'b1, "dropped");
    exp_rx = saved;
    repeat (3) @(negedge clk);
    check("rx_frames after drop", 32'(rx_acc), 32'(rx_frames));
    check_rx("pending after drop");
    ack_rx();

    @(negedge clk);
    check("final tx_frames", 32'(tx_sent), 32'(tx_frames));
    check("final rx_frames", 32'(rx_acc), 32'(rx_frames));
    check("final rx_err_frames", 32'(err_acc), 32'(rx_err_frames));
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", limit_cycles);
    $display("sim failed");
    $finish;
  end

endmodule
